//--- build.f
source/shell_pkg.sv
source/settings_if.sv
source/settings_regs.sv
source/control_mapper.sv
source/clock_enables.sv
source/video_out.sv
source/shell_top.sv
bench/shell_sva.sv
bench/tb_shell_top.sv

//--- bench/tb_shell_top.sv
// testbench for the control shell top level
// clock, reset, stimulus per test, watchdog, per-test and closing counts
`timescale 1ns/1ps
`default_nettype none

module tb_shell_top
  import shell_pkg::*;
();

  localparam int period       = 10;
  localparam int reset_cycles = 10;

  // test budgets in cycles, watchdog is their sum plus margin
  localparam int settings_len = 160;
  localparam int straight_len = 260;
  localparam int diagonal_len = 400;
  localparam int enable_len   = 4 * sound_div + 40;
  localparam int video_len    = 420;
  localparam int download_len = 80;
  localparam int margin_len   = 200;
  localparam int watchdog_cycles = reset_cycles + settings_len + straight_len + diagonal_len
                                 + enable_len + video_len + download_len + margin_len;

  logic                clk_40;
  logic                arst_n;
  logic [bridge_w-1:0] bridge_addr;
  logic                bridge_wr;
  logic [bridge_w-1:0] bridge_wr_data;
  logic                dataslot_requestwrite;
  logic                dataslot_allcomplete;
  logic [key_w-1:0]    cont1_key;
  logic [rgb_w-1:0]    rgb_in;
  logic                hblank_in;
  logic                vblank_in;
  logic                hs_in;
  logic                vs_in;
  wire  [bridge_w-1:0] bridge_rd_data;
  wire  [port_w-1:0]   ip_1710;
  wire  [port_w-1:0]   ip_4740;
  wire  [num_dips-1:0] dip_switch;
  wire                 rom_init;
  wire                 cpu_ce;
  wire                 sound_ce;
  wire                 pix_ce;
  wire  [rgb_w-1:0]    video_rgb;
  wire                 video_de;
  wire                 video_hs;
  wire                 video_vs;

  logic [31:0] rng_state = 32'd24536;
  string       test_name;
  int          test_num;
  int          fails_at_start;
  int          tests_failed;

  shell_top dut (
    .clk_40                (clk_40),
    .arst_n                (arst_n),
    .bridge_addr           (bridge_addr),
    .bridge_wr             (bridge_wr),
    .bridge_wr_data        (bridge_wr_data),
    .bridge_rd_data        (bridge_rd_data),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .cont1_key             (cont1_key),
    .ip_1710               (ip_1710),
    .ip_4740               (ip_4740),
    .dip_switch            (dip_switch),
    .rom_init              (rom_init),
    .cpu_ce                (cpu_ce),
    .sound_ce              (sound_ce),
    .pix_ce                (pix_ce),
    .rgb_in                (rgb_in),
    .hblank_in             (hblank_in),
    .vblank_in             (vblank_in),
    .hs_in                 (hs_in),
    .vs_in                 (vs_in),
    .video_rgb             (video_rgb),
    .video_de              (video_de),
    .video_hs              (video_hs),
    .video_vs              (video_vs)
  );

  initial clk_40 = 1'b0;
  always #(period / 2) clk_40 = ~clk_40;

  //////////////////////////////
  // helpers
  //////////////////////////////

  // xorshift32 stream
  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic int assertion_failures();
    return dut.u_sva.fail_count;
  endfunction

  // index 0 test mode, 1 to 8 the dips, 9 diagonal
  function automatic logic [bridge_w-1:0] setting_addr(input int i);
    if (i == 0) return addr_test_mode;
    if (i == num_dips + 1) return addr_diagonal;
    return bridge_w'(addr_dip_base + (i - 1) * addr_dip_step);
  endfunction

  // all stimulus tasks start and end just after a falling edge
  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk_40);
  endtask

  task automatic bridge_write(input logic [bridge_w-1:0] addr, input logic [bridge_w-1:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    idle(1);
    bridge_wr      = 1'b0;
    idle(1);
  endtask

  task automatic pulse_dataslot(input logic req, input logic done, input int gap);
    dataslot_requestwrite = req;
    dataslot_allcomplete  = done;
    idle(1);
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    idle(gap);
  endtask

  task automatic apply_reset(input int cycles);
    arst_n = 1'b0;
    idle(cycles);
    arst_n = 1'b1;
  endtask

  // random keys held for one to four cycles
  task automatic drive_keys(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = next_random();
      cont1_key = r[key_w-1:0];
      idle(1 + r[17:16]);
    end
  endtask

  // random pixels, frequent blanking, sync toggles now and then
  task automatic video_stream(input int cycles);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++) begin
      r = next_random();
      rgb_in = r[rgb_w-1:0];
      r = next_random();
      hblank_in = (r[3:0] < 4'd4);
      vblank_in = (r[7:4] == 4'd0);
      if (r[10:8] == 3'd0) hs_in = ~hs_in;
      if (r[14:11] == 4'd0) vs_in = ~vs_in;
      idle(1);
    end
  endtask

  task automatic start_test(input string name);
    test_num++;
    test_name      = name;
    fails_at_start = assertion_failures();
  endtask

  // let pending checks settle before counting
  task automatic finish_test();
    int n;
    idle(2);
    n = assertion_failures() - fails_at_start;
    if (n == 0) begin
      $display("test %0d %s: ok", test_num, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d assertion failures", test_num, test_name, n);
    end
  endtask

  //////////////////////////////
  // watchdog
  //////////////////////////////

  initial begin
    #(watchdog_cycles * period);
    $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    logic [31:0]         r;
    logic [bridge_w-1:0] a;
    bridge_addr           = '0;
    bridge_wr             = 1'b0;
    bridge_wr_data        = '0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    cont1_key             = '0;
    rgb_in                = '0;
    hblank_in             = 1'b0;
    vblank_in             = 1'b0;
    hs_in                 = 1'b0;
    vs_in                 = 1'b0;
    test_num              = 0;
    tests_failed          = 0;
    // reset edge just after time zero
    arst_n = 1'b1;
    #1 arst_n = 1'b0;
    idle(reset_cycles);
    arst_n = 1'b1;

    start_test("settings readback");
    repeat (2) begin
      for (int i = 0; i <= num_dips + 1; i++) bridge_write(setting_addr(i), next_random());
    end
    // same offsets with a nonzero region byte must not land
    for (int i = 0; i <= num_dips + 1; i++) begin
      r = next_random();
      a = setting_addr(i);
      bridge_write({r[31:24] | 8'h01, a[23:0]}, next_random());
    end
    for (int i = 0; i <= num_dips + 1; i++) begin
      bridge_addr = setting_addr(i);
      idle(1);
    end
    // aliases outside the settings region read zero
    for (int i = 0; i <= num_dips + 1; i++) begin
      r = next_random();
      a = setting_addr(i);
      bridge_addr = {r[31:24] | 8'h01, a[23:0]};
      idle(1);
    end
    for (int i = 0; i < 24; i++) begin
      r = next_random();
      bridge_addr = i[0] ? r : {8'h00, r[23:0]};
      idle(1);
    end
    finish_test();

    start_test("straight mapping");
    bridge_write(addr_diagonal, 32'd0);
    bridge_write(addr_test_mode, 32'd0);
    drive_keys(20);
    bridge_write(addr_test_mode, 32'd1);
    drive_keys(20);
    finish_test();

    start_test("diagonal mapping");
    bridge_write(addr_diagonal, 32'd1);
    drive_keys(40);
    bridge_write(addr_diagonal, 32'd0);
    drive_keys(20);
    finish_test();

    // fresh reset so the first pulses are seen again
    start_test("enable spacing");
    apply_reset(4);
    idle(4 * sound_div);
    finish_test();

    start_test("video stage");
    video_stream(400);
    finish_test();

    start_test("download flag");
    pulse_dataslot(1'b1, 1'b0, 3);
    pulse_dataslot(1'b0, 1'b1, 3);
    pulse_dataslot(1'b1, 1'b1, 3);
    pulse_dataslot(1'b1, 1'b1, 3);
    pulse_dataslot(1'b0, 1'b1, 2);
    pulse_dataslot(1'b1, 1'b0, 2);
    bridge_write(setting_addr(1), 32'd1);
    bridge_write(addr_test_mode, 32'd1);
    apply_reset(4);
    idle(4);
    finish_test();

    $display("%0d tests run, %0d failed, %0d assertion failures",
             test_num, tests_failed, assertion_failures());
    if (tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/shell_sva.sv
// bound checker for the control shell top level
// shadow of the bridge settings, key history, video sample history
// assertions for readback, port mapping, enables, video and download flag
`timescale 1ns/1ps
`default_nettype none

module shell_sva
  import shell_pkg::*;
(
  input wire                clk_40,
  input wire                arst_n,
  input wire [bridge_w-1:0] bridge_addr,
  input wire                bridge_wr,
  input wire [bridge_w-1:0] bridge_wr_data,
  input wire [bridge_w-1:0] bridge_rd_data,
  input wire                dataslot_requestwrite,
  input wire                dataslot_allcomplete,
  input wire [key_w-1:0]    cont1_key,
  input wire [port_w-1:0]   ip_1710,
  input wire [port_w-1:0]   ip_4740,
  input wire [num_dips-1:0] dip_switch,
  input wire                rom_init,
  input wire                test_mode,
  input wire                diagonal,
  input wire                cpu_ce,
  input wire                sound_ce,
  input wire                pix_ce,
  input wire [rgb_w-1:0]    rgb_in,
  input wire                hblank_in,
  input wire                vblank_in,
  input wire                hs_in,
  input wire                vs_in,
  input wire [rgb_w-1:0]    video_rgb,
  input wire                video_de,
  input wire                video_hs,
  input wire                video_vs
);

  // read by the testbench after each test
  int fail_count = 0;

  task automatic record_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  // dip n sits at base plus n-1 steps, shown in bit num_dips-n
  function automatic int dip_index(input logic [bridge_w-1:0] addr);
    for (int n = 1; n <= num_dips; n++) begin
      if (addr == bridge_w'(addr_dip_base + (n - 1) * addr_dip_step)) return num_dips - n;
    end
    return -1;
  endfunction

  //////////////////////////////
  // reference state
  //////////////////////////////

  logic                              sh_test;
  logic                              sh_diag;
  logic [num_dips-1:0]               sh_dip;
  logic                              rom_next_q;
  int unsigned                       since_rst;
  logic [sync_stages-1:0][key_w-1:0] key_hist;

  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      sh_test    <= 1'b0;
      sh_diag    <= 1'b0;
      sh_dip     <= '0;
      rom_next_q <= 1'b0;
      since_rst  <= 0;
    end else begin
      since_rst  <= since_rst + 1;
      // a request beats a completion
      rom_next_q <= dataslot_requestwrite | (rom_init & ~dataslot_allcomplete);
      if (bridge_wr && bridge_addr == addr_test_mode) sh_test <= bridge_wr_data[0];
      if (bridge_wr && bridge_addr == addr_diagonal) sh_diag <= bridge_wr_data[0];
      if (bridge_wr && dip_index(bridge_addr) >= 0) begin
        sh_dip[dip_index(bridge_addr)] <= bridge_wr_data[0];
      end
    end
  end

  // key word as it stood three edges ago
  always_ff @(posedge clk_40) begin
    key_hist <= {key_hist[sync_stages-2:0], cont1_key};
  end

  // video inputs and outputs at the previous edge
  logic             pix_q;
  logic             disp_q;
  logic [rgb_w-1:0] rgb_q;
  logic [rgb_w+2:0] out_q;
  logic             hs_seen;
  logic             vs_seen;
  logic             hs_rise_q;
  logic             vs_rise_q;
  wire  [rgb_w+2:0] video_now = {video_rgb, video_de, video_hs, video_vs};

  // sync levels at the last pixel sample
  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      hs_seen <= 1'b0;
      vs_seen <= 1'b0;
    end else if (pix_ce) begin
      hs_seen <= hs_in;
      vs_seen <= vs_in;
    end
  end

  always_ff @(posedge clk_40) begin
    pix_q     <= pix_ce;
    disp_q    <= !(hblank_in || vblank_in);
    rgb_q     <= rgb_in;
    out_q     <= video_now;
    hs_rise_q <= hs_in & ~hs_seen;
    vs_rise_q <= vs_in & ~vs_seen;
  end

  //////////////////////////////
  // expected values
  //////////////////////////////

  logic [bridge_w-1:0] exp_rd;
  logic [port_w-1:0]   exp_1710;
  logic [port_w-1:0]   exp_4740;
  logic [rgb_w-1:0]    exp_rgb;
  logic [key_w-1:0]    k;

  always_comb begin
    k      = key_hist[sync_stages-1];
    exp_rd = '0;
    if (bridge_addr == addr_test_mode) exp_rd[0] = sh_test;
    if (bridge_addr == addr_diagonal) exp_rd[0] = sh_diag;
    if (dip_index(bridge_addr) >= 0) exp_rd[0] = sh_dip[dip_index(bridge_addr)];
    // coin/start port
    exp_1710    = '0;
    exp_1710[7] = k[key_a];
    exp_1710[6] = ~sh_test;
    exp_1710[3] = k[key_select];
    exp_1710[1] = k[key_x];
    exp_1710[0] = k[key_start];
    // direction port, board pairings in diagonal mode
    exp_4740 = '0;
    if (sh_diag) begin
      exp_4740[3] = k[key_down] & k[key_left];
      exp_4740[2] = k[key_right] & k[key_down];
      exp_4740[1] = k[key_up] & k[key_right];
      exp_4740[0] = k[key_left] & k[key_up];
    end else begin
      exp_4740[3:0] = {k[key_left], k[key_right], k[key_up], k[key_down]};
    end
    // pixel only taken in display time
    exp_rgb = disp_q ? rgb_q : out_q[rgb_w+2:3];
  end

  // enable phase counted from reset release
  wire exp_cpu   = (since_rst != 0) && (since_rst % cpu_div == 0);
  wire exp_sound = (since_rst != 0) && (since_rst % sound_div == 0);
  wire exp_pix   = (since_rst != 0) && (since_rst % pix_div == 0);

  wire [rgb_w+num_dips+8:0] reset_out = {rom_init, test_mode, diagonal, dip_switch, cpu_ce,
                                         sound_ce, pix_ce, video_de, video_hs, video_vs,
                                         video_rgb};

  //////////////////////////////
  // checks
  //////////////////////////////

  readback_a: assert property (@(posedge clk_40) disable iff (!arst_n)
    bridge_rd_data == exp_rd)
    else record_failure($sformatf("[FAIL] bridge_rd_data addr %h got %h expected %h",
      $sampled(bridge_addr), $sampled(bridge_rd_data), $sampled(exp_rd)));

  dip_a: assert property (@(posedge clk_40) disable iff (!arst_n) dip_switch == sh_dip)
    else record_failure($sformatf("[FAIL] dip_switch got %h expected %h",
      $sampled(dip_switch), $sampled(sh_dip)));

  coin_a: assert property (@(posedge clk_40) disable iff (!arst_n)
    since_rst >= sync_stages |-> ip_1710 == exp_1710)
    else record_failure($sformatf("[FAIL] ip_1710 got %h expected %h",
      $sampled(ip_1710), $sampled(exp_1710)));

  dir_a: assert property (@(posedge clk_40) disable iff (!arst_n)
    since_rst >= sync_stages |-> ip_4740 == exp_4740)
    else record_failure($sformatf("[FAIL] ip_4740 got %h expected %h",
      $sampled(ip_4740), $sampled(exp_4740)));

  cpu_a: assert property (@(posedge clk_40) disable iff (!arst_n) cpu_ce == exp_cpu)
    else record_failure($sformatf("[FAIL] cpu_ce got %h expected %h at cycle %0d",
      $sampled(cpu_ce), $sampled(exp_cpu), $sampled(since_rst)));

  sound_a: assert property (@(posedge clk_40) disable iff (!arst_n) sound_ce == exp_sound)
    else record_failure($sformatf("[FAIL] sound_ce got %h expected %h at cycle %0d",
      $sampled(sound_ce), $sampled(exp_sound), $sampled(since_rst)));

  pix_a: assert property (@(posedge clk_40) disable iff (!arst_n) pix_ce == exp_pix)
    else record_failure($sformatf("[FAIL] pix_ce got %h expected %h at cycle %0d",
      $sampled(pix_ce), $sampled(exp_pix), $sampled(since_rst)));

  de_a: assert property (@(posedge clk_40) disable iff (!arst_n) pix_q |-> video_de == disp_q)
    else record_failure($sformatf("[FAIL] video_de got %h expected %h",
      $sampled(video_de), $sampled(disp_q)));

  rgb_a: assert property (@(posedge clk_40) disable iff (!arst_n)
    pix_q |-> video_rgb == exp_rgb)
    else record_failure($sformatf("[FAIL] video_rgb got %h expected %h",
      $sampled(video_rgb), $sampled(exp_rgb)));

  sync_a: assert property (@(posedge clk_40) disable iff (!arst_n)
    pix_q |-> {video_hs, video_vs} == {hs_rise_q, vs_rise_q})
    else record_failure($sformatf("[FAIL] video_hs/video_vs got %h expected %h",
      $sampled({video_hs, video_vs}), $sampled({hs_rise_q, vs_rise_q})));

  hold_a: assert property (@(posedge clk_40) disable iff (!arst_n)
    !pix_q |-> video_now == out_q)
    else record_failure($sformatf("[FAIL] video outputs got %h expected held %h",
      $sampled(video_now), $sampled(out_q)));

  rom_a: assert property (@(posedge clk_40) disable iff (!arst_n) rom_init == rom_next_q)
    else record_failure($sformatf("[FAIL] rom_init got %h expected %h",
      $sampled(rom_init), $sampled(rom_next_q)));

  // during reset and on the first edge after release
  reset_a: assert property (@(posedge clk_40)
    (!arst_n || $rose(arst_n)) |-> reset_out == '0)
    else record_failure($sformatf("[FAIL] control outputs in reset got %h expected 0",
      $sampled(reset_out)));

endmodule

bind shell_top shell_sva u_sva (
  .*,
  .test_mode (settings.test_mode),
  .diagonal  (settings.diagonal)
);

`default_nettype wire

//--- source/shell_top.sv
// control shell top level
// settings registers, control mapping, clock enables, video stage
// one settings bundle links the register block to its users
`timescale 1ns/1ps
`default_nettype none

module shell_top
  import shell_pkg::*;
(
  input  wire                 clk_40,
  input  wire                 arst_n,

  // host bridge
  input  wire  [bridge_w-1:0] bridge_addr,
  input  wire                 bridge_wr,
  input  wire  [bridge_w-1:0] bridge_wr_data,
  output wire  [bridge_w-1:0] bridge_rd_data,
  input  wire                 dataslot_requestwrite,
  input  wire                 dataslot_allcomplete,

  // player controls
  input  wire  [key_w-1:0]    cont1_key,
  output wire  [port_w-1:0]   ip_1710,
  output wire  [port_w-1:0]   ip_4740,

  // settings toward the game board
  output wire  [num_dips-1:0] dip_switch,
  output wire                 rom_init,

  // original clock rates as enables
  output wire                 cpu_ce,
  output wire                 sound_ce,
  output wire                 pix_ce,

  // game board video in
  input  wire  [rgb_w-1:0]    rgb_in,
  input  wire                 hblank_in,
  input  wire                 vblank_in,
  input  wire                 hs_in,
  input  wire                 vs_in,

  // scaler video out
  output wire  [rgb_w-1:0]    video_rgb,
  output wire                 video_de,
  output wire                 video_hs,
  output wire                 video_vs
);

  settings_if settings ();

  // dip_1 already in bit 7
  assign dip_switch = settings.dip;
  assign rom_init   = settings.rom_init;

  ////////////////////////////////
  // host side
  ////////////////////////////////

  settings_regs u_settings_regs (
    .clk_40                (clk_40),
    .arst_n                (arst_n),
    .bridge_addr           (bridge_addr),
    .bridge_wr             (bridge_wr),
    .bridge_wr_data        (bridge_wr_data),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .bridge_rd_data        (bridge_rd_data),
    .settings              (settings.regs)
  );

  control_mapper u_control_mapper (
    .clk_40    (clk_40),
    .arst_n    (arst_n),
    .cont1_key (cont1_key),
    .settings  (settings.user),
    .ip_1710   (ip_1710),
    .ip_4740   (ip_4740)
  );

  ////////////////////////////////
  // timing and video
  ////////////////////////////////

  clock_enables u_clock_enables (
    .clk_40   (clk_40),
    .arst_n   (arst_n),
    .cpu_ce   (cpu_ce),
    .sound_ce (sound_ce),
    .pix_ce   (pix_ce)
  );

  // pixel enable also paces the output stage
  video_out u_video_out (
    .clk_40    (clk_40),
    .arst_n    (arst_n),
    .pix_ce    (pix_ce),
    .rgb_in    (rgb_in),
    .hblank_in (hblank_in),
    .vblank_in (vblank_in),
    .hs_in     (hs_in),
    .vs_in     (vs_in),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

endmodule

`default_nettype wire

//--- source/video_out.sv
// video output stage
// display-time pixel capture, data enable, sync edge pulses
`timescale 1ns/1ps
`default_nettype none

module video_out
  import shell_pkg::*;
(
  input  wire              clk_40,
  input  wire              arst_n,
  input  wire              pix_ce,
  input  wire  [rgb_w-1:0] rgb_in,
  input  wire              hblank_in,
  input  wire              vblank_in,
  input  wire              hs_in,
  input  wire              vs_in,
  output logic [rgb_w-1:0] video_rgb,
  output logic             video_de,
  output logic             video_hs,
  output logic             video_vs
);

  // sync levels at the previous pixel sample
  logic hs_prev;
  logic vs_prev;
  logic display;

  // display time when neither blank is active
  assign display = ~(hblank_in | vblank_in);

  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else if (pix_ce) begin
      video_de <= display;
      // pixel held through blanking
      if (display) begin
        video_rgb <= rgb_in;
      end
      // one pixel period per rising sync edge
      video_hs <= ~hs_prev & hs_in;
      video_vs <= ~vs_prev & vs_in;
      hs_prev  <= hs_in;
      vs_prev  <= vs_in;
    end
  end

endmodule

`default_nettype wire

//--- source/clock_enables.sv
// cpu, sound and pixel enables on clk_40
// free-running dividers of the original clock ratios
`timescale 1ns/1ps
`default_nettype none

module clock_enables
  import shell_pkg::*;
(
  input  wire  clk_40,
  input  wire  arst_n,
  output logic cpu_ce,
  output logic sound_ce,
  output logic pix_ce
);

  logic [cpu_cnt_w-1:0]   cpu_cnt;
  logic [sound_cnt_w-1:0] sound_cnt;
  logic [pix_cnt_w-1:0]   pix_cnt;

  // each enable rises on the edge where its counter wraps
  // first pulse on edge div after reset release

  // cpu rate
  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      cpu_cnt <= '0;
      cpu_ce  <= 1'b0;
    end else if (cpu_cnt == cpu_cnt_w'(cpu_div - 1)) begin
      cpu_cnt <= '0;
      cpu_ce  <= 1'b1;
    end else begin
      cpu_cnt <= cpu_cnt + 1'b1;
      cpu_ce  <= 1'b0;
    end
  end

  // sound board rate
  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      sound_cnt <= '0;
      sound_ce  <= 1'b0;
    end else if (sound_cnt == sound_cnt_w'(sound_div - 1)) begin
      sound_cnt <= '0;
      sound_ce  <= 1'b1;
    end else begin
      sound_cnt <= sound_cnt + 1'b1;
      sound_ce  <= 1'b0;
    end
  end

  // pixel rate, replaces the old divided video clock
  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      pix_cnt <= '0;
      pix_ce  <= 1'b0;
    end else if (pix_cnt == pix_cnt_w'(pix_div - 1)) begin
      pix_cnt <= '0;
      pix_ce  <= 1'b1;
    end else begin
      pix_cnt <= pix_cnt + 1'b1;
      pix_ce  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/control_mapper.sv
// player-one key synchronizer
// builds the coin/start port and the direction port
`timescale 1ns/1ps
`default_nettype none

module control_mapper
  import shell_pkg::*;
(
  input  wire               clk_40,
  input  wire               arst_n,
  input  wire  [key_w-1:0]  cont1_key,
  settings_if.user          settings,
  output logic [port_w-1:0] ip_1710,
  output logic [port_w-1:0] ip_4740
);

  ////////////////////////////////
  // key synchronizer
  ////////////////////////////////

  logic [key_w-1:0] sync_q [sync_stages];
  logic [key_w-1:0] keys;

  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < sync_stages; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= cont1_key;
      // shift toward the last stage
      for (int i = 1; i < sync_stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // last stage feeds the ports directly
  assign keys = sync_q[sync_stages-1];

  ////////////////////////////////
  // port construction
  ////////////////////////////////

  // coin/start port, test switch is active low
  assign ip_1710 = {
    keys[key_a],          // test 1
    ~settings.test_mode,  // test 2
    2'b00,
    keys[key_select],     // coin 1
    1'b0,                 // coin 2 unused
    keys[key_x],          // player 2
    keys[key_start]       // player 1
  };

  // direction port, low nibble only
  always_comb begin
    if (settings.diagonal) begin
      // board pairings, kept as wired on the original
      ip_4740 = {
        4'b0000,
        keys[key_down] & keys[key_left],
        keys[key_right] & keys[key_down],
        keys[key_up] & keys[key_right],
        keys[key_left] & keys[key_up]
      };
    end else begin
      ip_4740 = {4'b0000, keys[key_left], keys[key_right], keys[key_up], keys[key_down]};
    end
  end

endmodule

`default_nettype wire

//--- source/settings_regs.sv
// bridge-written settings bits and their read path
// rom download flag from the data-slot events
`timescale 1ns/1ps
`default_nettype none

module settings_regs
  import shell_pkg::*;
(
  input  wire                 clk_40,
  input  wire                 arst_n,
  input  wire  [bridge_w-1:0] bridge_addr,
  input  wire                 bridge_wr,
  input  wire  [bridge_w-1:0] bridge_wr_data,
  input  wire                 dataslot_requestwrite,
  input  wire                 dataslot_allcomplete,
  output logic [bridge_w-1:0] bridge_rd_data,
  settings_if.regs            settings
);

  ////////////////////////////////
  // address decode
  ////////////////////////////////

  logic [bridge_w-region_w-1:0] offset;
  logic                         hit_test;
  logic                         hit_diag;
  logic [num_dips-1:0]          hit_dip;
  logic                         in_region;

  // offset below the region byte
  assign offset    = bridge_addr[bridge_w-region_w-1:0];
  assign in_region = (bridge_addr[bridge_w-1 -: region_w] == settings_region);

  // offset compare, shared by writes and reads
  always_comb begin
    hit_test = (offset == addr_test_mode[bridge_w-region_w-1:0]);
    hit_diag = (offset == addr_diagonal[bridge_w-region_w-1:0]);
    // dip_1 at base lands in the msb
    for (int i = 0; i < num_dips; i++) begin
      hit_dip[num_dips-1-i] =
        (offset == (bridge_w-region_w)'(addr_dip_base + i * addr_dip_step));
    end
  end

  ////////////////////////////////
  // settings bits
  ////////////////////////////////

  // only bit 0 of the write word is kept
  // writes outside the settings region are ignored
  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      settings.test_mode <= 1'b0;
      settings.diagonal  <= 1'b0;
      settings.dip       <= '0;
    end else if (bridge_wr && in_region) begin
      if (hit_test) settings.test_mode <= bridge_wr_data[0];
      if (hit_diag) settings.diagonal <= bridge_wr_data[0];
      for (int i = 0; i < num_dips; i++) begin
        if (hit_dip[i]) settings.dip[i] <= bridge_wr_data[0];
      end
    end
  end

  // download flag
  // request takes priority over completion
  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      settings.rom_init <= 1'b0;
    end else if (dataslot_requestwrite) begin
      settings.rom_init <= 1'b1;
    end else if (dataslot_allcomplete) begin
      settings.rom_init <= 1'b0;
    end
  end

  ////////////////////////////////
  // read path
  ////////////////////////////////

  // same cycle as the address, zero outside the map
  always_comb begin
    bridge_rd_data = '0;
    if (in_region) begin
      if (hit_test) bridge_rd_data[0] = settings.test_mode;
      if (hit_diag) bridge_rd_data[0] = settings.diagonal;
      for (int i = 0; i < num_dips; i++) begin
        if (hit_dip[i]) bridge_rd_data[0] = settings.dip[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/settings_if.sv
// host settings bundle
// register block drives, control mapping and top read
`timescale 1ns/1ps
`default_nettype none

interface settings_if
  import shell_pkg::*;
();

  // plain levels, no handshake
  logic                test_mode;
  logic                diagonal;
  // dip_1 sits in the msb
  logic [num_dips-1:0] dip;
  // rom download in progress
  logic                rom_init;

  modport regs (output test_mode, output diagonal, output dip, output rom_init);

  modport user (input test_mode, input diagonal, input dip, input rom_init);

endinterface

`default_nettype wire

//--- source/shell_pkg.sv
// shared constants for the control shell
// bridge addresses, bus and key widths, key bit indices
// divider counts for the clock-enable strobes
`default_nettype none

package shell_pkg;

  ////////////////////////////////
  // bridge bus
  ////////////////////////////////

  localparam int bridge_w = 32;
  localparam int region_w = 8;

  // settings live in the lowest region of the bridge map
  localparam logic [region_w-1:0] settings_region = 8'h00;

  // one word per setting
  localparam logic [bridge_w-1:0] addr_test_mode = 32'h0000_0000;
  localparam logic [bridge_w-1:0] addr_dip_base  = 32'h0000_0010;
  localparam logic [bridge_w-1:0] addr_dip_step  = 32'h0000_0010;
  localparam logic [bridge_w-1:0] addr_diagonal  = 32'h0000_0090;

  localparam int num_dips = 8;

  ////////////////////////////////
  // controls and video
  ////////////////////////////////

  localparam int key_w  = 16;
  localparam int port_w = 8;

  // player key bitmap positions
  localparam int key_up     = 0;
  localparam int key_down   = 1;
  localparam int key_left   = 2;
  localparam int key_right  = 3;
  localparam int key_a      = 4;
  localparam int key_x      = 6;
  localparam int key_select = 14;
  localparam int key_start  = 15;

  localparam int sync_stages = 3;
  localparam int rgb_w       = 24;

  ////////////////////////////////
  // original clock tree ratios
  ////////////////////////////////

  localparam int cpu_div   = 10;
  localparam int sound_div = 44;
  localparam int pix_div   = 8;

  // counter widths follow from the ratios
  localparam int cpu_cnt_w   = $clog2(cpu_div);
  localparam int sound_cnt_w = $clog2(sound_div);
  localparam int pix_cnt_w   = $clog2(pix_div);

endpackage

`default_nettype wire
